// File: logic/acq_pkg.sv
`default_nettype none

package acq_pkg;

    localparam int ADC_WIDTH        = 12;
    localparam int SAMPLES_PER_BEAT = 8;
    localparam int SLOT_WIDTH       = 16;
    localparam int WORD_WIDTH       = 64;
    localparam int STAMP_WIDTH      = 16;

    // One converter sample, unsigned
    typedef logic [ADC_WIDTH-1:0] adc_sample_t;

    // Eight 16-bit slots, sample sits in the low 12 bits of each
    typedef logic [SAMPLES_PER_BEAT*SLOT_WIDTH-1:0] s_beat_t;

    // Output stream word
    typedef logic [WORD_WIDTH-1:0] m_word_t;

    // Trigger time in prescaled ticks
    typedef logic [STAMP_WIDTH-1:0] time_stamp_t;

    typedef enum logic
    {
        CALIB,
        RUN
    } acq_state_t;

    // Sample of one slot, upper slot bits dropped
    function automatic adc_sample_t slot_sample(input s_beat_t beat, input int slot);
        return beat[slot*SLOT_WIDTH +: ADC_WIDTH];
    endfunction

endpackage

`default_nettype wire

// File: logic/capture_if.sv
`timescale 1ns/10ps
`default_nettype none

interface capture_if;

    // Captured beat stream, one beat per strobe
    logic                 beat_valid;
    acq_pkg::s_beat_t     beat;
    logic                 first;
    logic                 last;

    // Header fields, valid with first
    acq_pkg::time_stamp_t stamp;
    acq_pkg::adc_sample_t minimum;
    acq_pkg::adc_sample_t baseline;

    // Output FIFO can hold a whole record
    logic                 room;

    modport producer (
        output beat_valid, beat, first, last, stamp, minimum, baseline,
        input  room
    );

    modport consumer (
        input  beat_valid, beat, first, last, stamp, minimum, baseline,
        output room
    );

endinterface

`default_nettype wire

// File: logic/acq_control.sv
`timescale 1ns/10ps
`default_nettype none

module acq_control
(
    input  logic                AXIS_ACLK,
    input  logic                AXIS_ARESETN,
    input  logic                calc_done,
    output acq_pkg::acq_state_t state,
    output logic                s_axis_tready
);

    acq_pkg::acq_state_t state_next;

    always_comb
    begin
        state_next = state;
        case (state)
            acq_pkg::CALIB:
            begin
                if (calc_done)
                begin
                    state_next = acq_pkg::RUN;
                end
            end
            default:
            begin
                // RUN is held until the next reset
                state_next = acq_pkg::RUN;
            end
        endcase
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            state         <= acq_pkg::CALIB;
            s_axis_tready <= 1'b0;
        end
        else
        begin
            state         <= state_next;
            // Input opens one cycle after RUN is entered
            s_axis_tready <= (state == acq_pkg::RUN);
        end
    end

    // RUN rests on a finished calibration that stays done until reset
    a_run_after_calib: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        state == acq_pkg::RUN |-> calc_done
    );

endmodule

`default_nettype wire

// File: logic/baseline_calc.sv
`timescale 1ns/10ps
`default_nettype none

module baseline_calc
#(
    parameter int BASELINE_BEATS = 16
)
(
    input  logic                 AXIS_ACLK,
    input  logic                 AXIS_ARESETN,
    input  acq_pkg::acq_state_t  state,
    input  acq_pkg::s_beat_t     s_axis_tdata,
    input  logic                 s_axis_tvalid,
    output acq_pkg::adc_sample_t baseline,
    output logic                 calc_done
);

    // Sample count is a power of two, so the average is a plain shift
    localparam int SHIFT = $clog2(acq_pkg::SAMPLES_PER_BEAT * BASELINE_BEATS);
    localparam int SUM_W = acq_pkg::ADC_WIDTH + $clog2(acq_pkg::SAMPLES_PER_BEAT);
    localparam int ACC_W = acq_pkg::ADC_WIDTH + SHIFT;
    localparam int CNT_W = $clog2(BASELINE_BEATS + 1);

    logic [SUM_W-1:0] beat_sum;
    logic [ACC_W-1:0] acc;
    logic [CNT_W-1:0] beat_cnt;
    logic             counted;

    always_comb
    begin
        beat_sum = '0;
        for (int i = 0; i < acq_pkg::SAMPLES_PER_BEAT; i++)
        begin
            beat_sum = beat_sum + SUM_W'(acq_pkg::slot_sample(s_axis_tdata, i));
        end
    end

    assign counted = (beat_cnt == CNT_W'(BASELINE_BEATS));

    // Valid alone qualifies a beat here, tready is still low in CALIB
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            acc       <= '0;
            beat_cnt  <= '0;
            calc_done <= 1'b0;
        end
        else
        begin
            if (state == acq_pkg::CALIB && !counted && s_axis_tvalid)
            begin
                acc      <= acc + ACC_W'(beat_sum);
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (counted)
            begin
                calc_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (counted && !calc_done)
        begin
            baseline <= acc[SHIFT +: acq_pkg::ADC_WIDTH];
        end
    end

endmodule

`default_nettype wire

// File: logic/time_counter.sv
`timescale 1ns/10ps
`default_nettype none

module time_counter
#(
    parameter int TICK_DIV = 5
)
(
    input  logic                 AXIS_ACLK,
    input  logic                 AXIS_ARESETN,
    input  acq_pkg::acq_state_t  state,
    input  logic                 s_axis_tready,
    output acq_pkg::time_stamp_t now
);

    localparam int PRESC_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PRESC_W-1:0] presc;
    logic               running;

    assign running = (state == acq_pkg::RUN) && s_axis_tready;

    // Counting starts on the first cycle the input is open, now wraps freely
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN || !running)
        begin
            presc <= '0;
            now   <= '0;
        end
        else if (presc == PRESC_W'(TICK_DIV - 1))
        begin
            presc <= '0;
            now   <= now + 1'b1;
        end
        else
        begin
            presc <= presc + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/min_trigger.sv
`timescale 1ns/10ps
`default_nettype none

module min_trigger
#(
    parameter int THRESHOLD  = 40,
    parameter int PRE_BEATS  = 2,
    parameter int POST_BEATS = 3
)
(
    input  logic                 AXIS_ACLK,
    input  logic                 AXIS_ARESETN,
    input  acq_pkg::acq_state_t  state,
    input  acq_pkg::adc_sample_t baseline,
    input  acq_pkg::time_stamp_t now,
    input  acq_pkg::s_beat_t     s_axis_tdata,
    input  logic                 s_axis_tvalid,
    input  logic                 s_axis_tready,
    capture_if.producer          cap
);

    localparam int WIN_BEATS = PRE_BEATS + 1 + POST_BEATS;
    localparam int IDX_W     = $clog2(WIN_BEATS + 1);
    localparam int HCNT_W    = $clog2(PRE_BEATS + 1);

    acq_pkg::s_beat_t     hist [PRE_BEATS];
    acq_pkg::s_beat_t     win  [WIN_BEATS];
    acq_pkg::adc_sample_t beat_min;
    acq_pkg::time_stamp_t stamp_q;
    acq_pkg::adc_sample_t min_q;
    logic [HCNT_W-1:0]    hist_cnt;
    logic [IDX_W-1:0]     wr_idx;
    logic [IDX_W-1:0]     rd_idx;
    logic [IDX_W-1:0]     unread;
    logic                 capturing;
    logic                 accept;
    logic                 busy;
    logic                 trigger;

    always_comb
    begin
        beat_min = acq_pkg::slot_sample(s_axis_tdata, 0);
        for (int i = 1; i < acq_pkg::SAMPLES_PER_BEAT; i++)
        begin
            if (acq_pkg::slot_sample(s_axis_tdata, i) < beat_min)
            begin
                beat_min = acq_pkg::slot_sample(s_axis_tdata, i);
            end
        end
    end

    assign accept = s_axis_tvalid && s_axis_tready && (state == acq_pkg::RUN);
    assign unread = wr_idx - rd_idx;

    // Open until the last post beat is in and at most one beat is left to show.
    // That last beat is read out in the same cycle the window is reloaded.
    assign busy    = capturing || (unread > IDX_W'(1));
    assign trigger = accept && !busy && cap.room
                     && (hist_cnt == HCNT_W'(PRE_BEATS))
                     && (int'(beat_min) < int'(baseline) - THRESHOLD);

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            hist_cnt  <= '0;
            wr_idx    <= '0;
            rd_idx    <= '0;
            capturing <= 1'b0;
        end
        else
        begin
            if (accept && hist_cnt != HCNT_W'(PRE_BEATS))
            begin
                hist_cnt <= hist_cnt + 1'b1;
            end
            if (trigger)
            begin
                wr_idx    <= IDX_W'(PRE_BEATS + 1);
                rd_idx    <= '0;
                capturing <= (POST_BEATS != 0);
            end
            else
            begin
                if (capturing && accept)
                begin
                    wr_idx <= wr_idx + 1'b1;
                    if (wr_idx == IDX_W'(WIN_BEATS - 1))
                    begin
                        capturing <= 1'b0;
                    end
                end
                // Window drains one beat per cycle
                if (unread != '0)
                begin
                    rd_idx <= rd_idx + 1'b1;
                end
            end
        end
    end

    // History newest first, window oldest first
    always_ff @(posedge AXIS_ACLK)
    begin
        if (accept)
        begin
            hist[0] <= s_axis_tdata;
            for (int i = 1; i < PRE_BEATS; i++)
            begin
                hist[i] <= hist[i-1];
            end
        end
        if (trigger)
        begin
            for (int i = 0; i < PRE_BEATS; i++)
            begin
                win[i] <= hist[PRE_BEATS-1-i];
            end
            win[PRE_BEATS] <= s_axis_tdata;
            stamp_q        <= now;
            min_q          <= beat_min;
        end
        else if (capturing && accept)
        begin
            win[wr_idx] <= s_axis_tdata;
        end
    end

    assign cap.beat_valid = (unread != '0);
    assign cap.beat       = win[rd_idx];
    assign cap.first      = cap.beat_valid && (rd_idx == '0);
    assign cap.last       = cap.beat_valid && (rd_idx == IDX_W'(WIN_BEATS - 1));
    assign cap.stamp      = stamp_q;
    assign cap.minimum    = min_q;
    assign cap.baseline   = baseline;

    // After a closing beat the only beat allowed is the opening of a new record
    a_beat_inside_record: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        cap.last |=> (!cap.beat_valid || cap.first)
    );

endmodule

`default_nettype wire

// File: logic/event_packer.sv
`timescale 1ns/10ps
`default_nettype none

module event_packer
#(
    parameter int PRE_BEATS  = 2,
    parameter int POST_BEATS = 3,
    parameter int FIFO_WORDS = 64
)
(
    input  logic             AXIS_ACLK,
    input  logic             AXIS_ARESETN,
    capture_if.consumer      cap,
    output acq_pkg::m_word_t m_axis_tdata,
    output logic             m_axis_tvalid,
    input  logic             m_axis_tready,
    output logic             m_axis_tlast,
    output logic             m_axis_tuser,
    output logic             fifo_full
);

    localparam int REC_WORDS = 1 + 2 * (PRE_BEATS + 1 + POST_BEATS);
    localparam int AW        = $clog2(FIFO_WORDS);
    localparam int CW        = AW + 1;
    localparam int HALF      = $bits(acq_pkg::m_word_t);

    typedef struct packed {
        logic             user;
        logic             last;
        acq_pkg::m_word_t data;
    } entry_t;

    entry_t           mem [FIFO_WORDS];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic [CW-1:0]    rsv;
    logic [1:0]       wr_n;
    logic             rd;
    acq_pkg::m_word_t header;
    acq_pkg::m_word_t beat_lo;
    acq_pkg::m_word_t beat_hi;

    // Stamp 63:48, baseline 43:32, minimum 11:0
    assign header  = {cap.stamp, 4'b0, cap.baseline, 20'b0, cap.minimum};
    assign beat_lo = cap.beat[HALF-1:0];
    assign beat_hi = cap.beat[2*HALF-1:HALF];

    always_comb
    begin
        if (!cap.beat_valid)
        begin
            wr_n = 2'd0;
        end
        else if (cap.first)
        begin
            wr_n = 2'd3;
        end
        else
        begin
            wr_n = 2'd2;
        end
    end

    assign rd = m_axis_tvalid && m_axis_tready;

    // Up to three words land per captured beat
    always_ff @(posedge AXIS_ACLK)
    begin
        if (cap.beat_valid && cap.first)
        begin
            mem[wr_ptr]          <= '{user: 1'b1, last: 1'b0, data: header};
            mem[wr_ptr + AW'(1)] <= '{user: 1'b0, last: 1'b0, data: beat_lo};
            mem[wr_ptr + AW'(2)] <= '{user: 1'b0, last: cap.last, data: beat_hi};
        end
        else if (cap.beat_valid)
        begin
            mem[wr_ptr]          <= '{user: 1'b0, last: 1'b0, data: beat_lo};
            mem[wr_ptr + AW'(1)] <= '{user: 1'b0, last: cap.last, data: beat_hi};
        end
    end

    // rsv counts stored words plus the unwritten rest of the open record
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rsv    <= '0;
        end
        else
        begin
            wr_ptr <= wr_ptr + AW'(wr_n);
            if (rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CW'(wr_n) - CW'(rd);
            if (cap.beat_valid && cap.first)
            begin
                rsv <= rsv + CW'(REC_WORDS) - CW'(rd);
            end
            else
            begin
                rsv <= rsv - CW'(rd);
            end
        end
    end

    assign cap.room  = (FIFO_WORDS - int'(rsv)) >= REC_WORDS;
    assign fifo_full = !cap.room;

    assign m_axis_tvalid = (count != '0);
    assign m_axis_tdata  = mem[rd_ptr].data;
    assign m_axis_tlast  = m_axis_tvalid && mem[rd_ptr].last;
    assign m_axis_tuser  = m_axis_tvalid && mem[rd_ptr].user;

    // The trigger only opens a record while room is high
    a_fifo_no_overflow: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        cap.beat_valid |-> (int'(count) + int'(wr_n) <= FIFO_WORDS)
    );

    a_tdata_stable_on_stall: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
    );

endmodule

`default_nettype wire

// File: logic/pulse_acq_top.sv
`timescale 1ns/10ps
`default_nettype none

module pulse_acq_top
#(
    parameter int THRESHOLD      = 40,
    parameter int BASELINE_BEATS = 16,
    parameter int PRE_BEATS      = 2,
    parameter int POST_BEATS     = 3,
    parameter int TICK_DIV       = 5,
    parameter int FIFO_WORDS     = 64
)
(
    input  logic             AXIS_ACLK,
    input  logic             AXIS_ARESETN,

    // Converter stream in
    input  acq_pkg::s_beat_t s_axis_tdata,
    input  logic             s_axis_tvalid,
    output logic             s_axis_tready,

    // Record stream out
    output acq_pkg::m_word_t m_axis_tdata,
    output logic             m_axis_tvalid,
    input  logic             m_axis_tready,
    output logic             m_axis_tlast,
    output logic             m_axis_tuser,

    output logic             fifo_full
);

    acq_pkg::acq_state_t  state;
    acq_pkg::adc_sample_t baseline;
    acq_pkg::time_stamp_t now;
    logic                 calc_done;

    capture_if cap_if ();

    acq_control acq_control_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .calc_done     (calc_done),
        .state         (state),
        .s_axis_tready (s_axis_tready)
    );

    baseline_calc #(
        .BASELINE_BEATS (BASELINE_BEATS)
    ) baseline_calc_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .state         (state),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .baseline      (baseline),
        .calc_done     (calc_done)
    );

    time_counter #(
        .TICK_DIV (TICK_DIV)
    ) time_counter_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .state         (state),
        .s_axis_tready (s_axis_tready),
        .now           (now)
    );

    min_trigger #(
        .THRESHOLD  (THRESHOLD),
        .PRE_BEATS  (PRE_BEATS),
        .POST_BEATS (POST_BEATS)
    ) min_trigger_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .state         (state),
        .baseline      (baseline),
        .now           (now),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .cap           (cap_if.producer)
    );

    event_packer #(
        .PRE_BEATS  (PRE_BEATS),
        .POST_BEATS (POST_BEATS),
        .FIFO_WORDS (FIFO_WORDS)
    ) event_packer_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .cap           (cap_if.consumer),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .fifo_full     (fifo_full)
    );

endmodule

`default_nettype wire

// File: dv/acq_model.svh
`ifndef ACQ_MODEL_SVH
`define ACQ_MODEL_SVH

// One expected output word with its sideband flags
typedef struct packed {
    logic             user;
    logic             last;
    acq_pkg::m_word_t data;
} exp_word_t;

localparam int REC_WORDS = 1 + 2 * (PRE_BEATS + 1 + POST_BEATS);
localparam int HALF_W    = $bits(acq_pkg::m_word_t);

exp_word_t            expect_q [$];
acq_pkg::s_beat_t     hist_q [$];
int                   calib_beats    = 0;
int                   calib_sum      = 0;
acq_pkg::adc_sample_t model_baseline = '0;
int                   ready_cycle    = -1;
int                   run_cycles     = 0;
int                   posts_left     = 0;
int                   last_pres      = -1;
int                   first_due      = -1;
int                   rsv_words      = 0;

// Sample sits in the low bits of its 16-bit slot
function automatic acq_pkg::adc_sample_t sample_at(input acq_pkg::s_beat_t beat, input int slot);
    return beat[slot*acq_pkg::SLOT_WIDTH +: $bits(acq_pkg::adc_sample_t)];
endfunction

function automatic acq_pkg::adc_sample_t lowest_sample(input acq_pkg::s_beat_t beat);
    acq_pkg::adc_sample_t m;
    m = sample_at(beat, 0);
    for (int i = 1; i < acq_pkg::SAMPLES_PER_BEAT; i++)
    begin
        if (sample_at(beat, i) < m)
        begin
            m = sample_at(beat, i);
        end
    end
    return m;
endfunction

// Free space below one whole record
function automatic logic fifo_space_short();
    return (FIFO_WORDS - rsv_words) < REC_WORDS;
endfunction

function automatic logic record_pending(input int c);
    return (posts_left != 0) || (last_pres >= c);
endfunction

task automatic push_beat_words(input acq_pkg::s_beat_t beat, input logic closes);
    exp_word_t w;
    w.user = 1'b0;
    w.last = 1'b0;
    w.data = beat[HALF_W-1:0];
    expect_q.push_back(w);
    w.last = closes;
    w.data = beat[2*HALF_W-1:HALF_W];
    expect_q.push_back(w);
endtask

// One clock of the model, with the inputs and output transfer of that cycle
task automatic step_model(input int c, input logic valid, input acq_pkg::s_beat_t beat,
                          input logic ready, input logic xfer);
    acq_pkg::adc_sample_t mn;
    acq_pkg::m_word_t     hdr;
    exp_word_t            w;
    logic                 accepted;
    logic                 room;
    logic                 open_rec;

    room     = !fifo_space_short();
    accepted = valid && ready;
    mn       = lowest_sample(beat);
    open_rec = (posts_left != 0) || (last_pres > c);

    // Baseline from the first valid beats after reset
    if (valid && calib_beats < BASELINE_BEATS)
    begin
        for (int i = 0; i < acq_pkg::SAMPLES_PER_BEAT; i++)
        begin
            calib_sum += int'(sample_at(beat, i));
        end
        calib_beats++;
        if (calib_beats == BASELINE_BEATS)
        begin
            model_baseline = acq_pkg::adc_sample_t'(
                calib_sum / (acq_pkg::SAMPLES_PER_BEAT * BASELINE_BEATS));
            // Count done, calc_done, RUN, then tready
            ready_cycle = c + 4;
        end
    end

    if (accepted && posts_left != 0)
    begin
        // Post beat shows once captured and after the beat before it
        last_pres = (c + 1 > last_pres + 1) ? c + 1 : last_pres + 1;
        posts_left--;
        push_beat_words(beat, posts_left == 0);
    end
    else if (accepted && !open_rec && room && hist_q.size() == PRE_BEATS
             && int'(mn) < int'(model_baseline) - THRESHOLD)
    begin
        hdr        = '0;
        hdr[63:48] = acq_pkg::time_stamp_t'(run_cycles / TICK_DIV);
        hdr[43:32] = model_baseline;
        hdr[11:0]  = mn;
        w.user     = 1'b1;
        w.last     = 1'b0;
        w.data     = hdr;
        expect_q.push_back(w);
        foreach (hist_q[i])
        begin
            push_beat_words(hist_q[i], 1'b0);
        end
        push_beat_words(beat, POST_BEATS == 0);
        posts_left = POST_BEATS;
        last_pres  = c + PRE_BEATS + 1;
        first_due  = c + 1;
    end

    // Space for a record is claimed when its opening beat reaches the FIFO
    if (first_due == c)
    begin
        rsv_words += REC_WORDS;
    end
    if (xfer)
    begin
        rsv_words--;
    end

    if (accepted)
    begin
        hist_q.push_back(beat);
        if (hist_q.size() > PRE_BEATS)
        begin
            hist_q.delete(0);
        end
    end
    if (ready)
    begin
        run_cycles++;
    end
endtask

`endif

// File: dv/tb_pulse_acq.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pulse_acq;

    localparam int THRESHOLD      = 40;
    localparam int BASELINE_BEATS = 16;
    localparam int PRE_BEATS      = 2;
    localparam int POST_BEATS     = 3;
    localparam int TICK_DIV       = 5;
    localparam int FIFO_WORDS     = 64;

    localparam int RESET_CYCLES   = 16;
    localparam int PHASE_A_CYCLES = 500;
    localparam int PHASE_B_CYCLES = 300;
    localparam int PHASE_C_CYCLES = 500;
    localparam int STIM_BEATS     = RESET_CYCLES + BASELINE_BEATS + PHASE_A_CYCLES
                                    + PHASE_B_CYCLES + PHASE_C_CYCLES;
    localparam int DRAIN_CYCLES   = 2 * FIFO_WORDS + 100;
    localparam int TIMEOUT_CYCLES = 4 * STIM_BEATS + DRAIN_CYCLES;
    localparam int MIN_RECORDS    = 10;

    // Noise band around the input level, dips go far below threshold
    localparam int NOISE_LEVEL = 2000;
    localparam int NOISE_SPAN  = 15;
    localparam int DIP_MIN     = 60;
    localparam int DIP_RANGE   = 400;

    logic             AXIS_ACLK;
    logic             AXIS_ARESETN;
    acq_pkg::s_beat_t s_axis_tdata;
    logic             s_axis_tvalid;
    logic             s_axis_tready;
    acq_pkg::m_word_t m_axis_tdata;
    logic             m_axis_tvalid;
    logic             m_axis_tready;
    logic             m_axis_tlast;
    logic             m_axis_tuser;
    logic             fifo_full;

    integer seed;
    int     cyc       = 0;
    int     clk_count = 0;
    int     rec_count = 0;
    logic   saw_full  = 1'b0;

    `include "acq_model.svh"

    pulse_acq_top #(
        .THRESHOLD      (THRESHOLD),
        .BASELINE_BEATS (BASELINE_BEATS),
        .PRE_BEATS      (PRE_BEATS),
        .POST_BEATS     (POST_BEATS),
        .TICK_DIV       (TICK_DIV),
        .FIFO_WORDS     (FIFO_WORDS)
    ) UUT (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .fifo_full     (fifo_full)
    );

    always #5 AXIS_ACLK = ~AXIS_ACLK;

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input acq_pkg::m_word_t got,
                              input acq_pkg::m_word_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Noise in every slot, random junk in the unused upper slot bits
    function automatic acq_pkg::s_beat_t make_beat(input logic dip);
        acq_pkg::s_beat_t b;
        int               slot;
        for (int i = 0; i < acq_pkg::SAMPLES_PER_BEAT; i++)
        begin
            b[i*acq_pkg::SLOT_WIDTH +: acq_pkg::SLOT_WIDTH] = {
                4'(rand_below(16)),
                12'(NOISE_LEVEL - NOISE_SPAN + rand_below(2 * NOISE_SPAN + 1))
            };
        end
        if (dip)
        begin
            slot = rand_below(acq_pkg::SAMPLES_PER_BEAT);
            b[slot*acq_pkg::SLOT_WIDTH +: 12] = 12'(NOISE_LEVEL - DIP_MIN - rand_below(DIP_RANGE));
        end
        return b;
    endfunction

    task automatic score_output_word();
        exp_word_t e;
        if (expect_q.size() == 0)
        begin
            $display("ERROR: output word 0x%h arrived while no record was expected",
                     m_axis_tdata);
            abort_run();
        end
        e = expect_q.pop_front();
        check_word("m_axis_tdata", m_axis_tdata, e.data);
        check_flag("m_axis_tuser", m_axis_tuser, e.user);
        check_flag("m_axis_tlast", m_axis_tlast, e.last);
        if (e.user)
        begin
            rec_count++;
        end
    endtask

    // Outputs are stable at the falling edge, new inputs go out at the same point
    task automatic run_cycle(input int valid_pct, input int dip_pct, input int ready_pct);
        acq_pkg::s_beat_t beat;
        logic             valid;
        logic             out_ready;
        logic             xfer;
        @(negedge AXIS_ACLK);
        check_flag("s_axis_tready", s_axis_tready, (ready_cycle >= 0) && (cyc >= ready_cycle));
        check_level("fifo_full", fifo_full, fifo_space_short());
        if (fifo_full)
        begin
            saw_full = 1'b1;
        end
        valid     = rand_below(100) < valid_pct;
        beat      = make_beat(rand_below(100) < dip_pct);
        out_ready = rand_below(100) < ready_pct;
        s_axis_tvalid = valid;
        s_axis_tdata  = beat;
        m_axis_tready = out_ready;
        xfer = m_axis_tvalid && out_ready;
        if (xfer)
        begin
            score_output_word();
        end
        step_model(cyc, valid, beat, s_axis_tready, xfer);
        cyc++;
    endtask

    always @(posedge AXIS_ACLK)
    begin
        clk_count++;
        if (clk_count >= TIMEOUT_CYCLES)
        begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial
    begin
        AXIS_ACLK     = 1'b0;
        AXIS_ARESETN  = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_tdata  = '0;
        m_axis_tready = 1'b0;
        seed          = 16860;
        repeat (RESET_CYCLES) @(negedge AXIS_ACLK);
        AXIS_ARESETN = 1'b1;

        // Calibration, noise only
        while (!s_axis_tready)
        begin
            run_cycle(75, 0, 100);
        end

        // Free-running output
        repeat (PHASE_A_CYCLES) run_cycle(75, 6, 100);

        // Output stalled long enough to fill the FIFO
        repeat (PHASE_B_CYCLES) run_cycle(75, 8, 0);

        // Random output back-pressure
        repeat (PHASE_C_CYCLES) run_cycle(60, 6, 50);

        // Drain on noise alone
        while (expect_q.size() != 0 || record_pending(cyc))
        begin
            run_cycle(60, 0, 100);
        end
        repeat (20) run_cycle(60, 0, 100);
        check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
        check_level("fifo_full", fifo_full, 1'b0);

        if (!saw_full)
        begin
            $display("ERROR: fifo_full never rose while the output was stalled");
            abort_run();
        end
        else if (rec_count < MIN_RECORDS)
        begin
            $display("ERROR: only %0d records came out", rec_count);
            abort_run();
        end
        else
        begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+dv
logic/acq_pkg.sv
logic/capture_if.sv
logic/acq_control.sv
logic/baseline_calc.sv
logic/time_counter.sv
logic/min_trigger.sv
logic/event_packer.sv
logic/pulse_acq_top.sv
dv/tb_pulse_acq.sv

// File: Makefile
TOP := tb_pulse_acq

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim 2>&1)"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
